/* verilog/pkt_width_pkg.sv */
/*
 * Shared widths, word layouts and state encoding for the packet width bridge.
 * Imported by every RTL module and by the testbench.
 * Bytes are big-endian, so byte 0 of a word sits in the top bits.
 */
package pkt_width_pkg;

    // Bus widths in bytes
    localparam int NARROW_BYTES = 4;
    localparam int WIDE_BYTES   = 16;
    localparam int CONV_RATIO   = WIDE_BYTES / NARROW_BYTES;

    // Credit buffer depth, which is also the number of credits at reset
    localparam int BUF_DEPTH = 8;

    localparam int NARROW_MTY_W = $clog2(NARROW_BYTES);
    localparam int WIDE_MTY_W   = $clog2(WIDE_BYTES);
    localparam int META_W       = 8;

    // Counters that must reach their upper bound need one extra value
    localparam int PACK_CNT_W = $clog2(CONV_RATIO + 1);
    localparam int CREDIT_W   = $clog2(BUF_DEPTH + 1);
    localparam int PTR_W      = $clog2(BUF_DEPTH);

    typedef logic [0:NARROW_BYTES-1][7:0] narrow_data_t;

    typedef struct packed {
        narrow_data_t            data;
        logic                    sop;
        logic                    eop;
        logic [NARROW_MTY_W-1:0] mty;
        logic                    err;
        logic [META_W-1:0]       meta;
    } narrow_word_t;

    // A wide word is CONV_RATIO narrow slots, slot 0 first on the wire
    typedef struct packed {
        narrow_data_t [0:CONV_RATIO-1] data;
        logic                          sop;
        logic                          eop;
        logic [WIDE_MTY_W-1:0]         mty;
        logic                          err;
        logic [META_W-1:0]             meta;
    } wide_word_t;

    typedef enum logic {
        UNPACK_IDLE,
        UNPACK_BUSY
    } unpack_state_t;

endpackage

/* verilog/pkt_upsizer.sv */
/*
 * Packs narrow packet words into wide words, slot 0 first.
 * A finished group is pushed to the credit buffer only while a credit
 * is held, and in_rdy drops while a finished group waits for one.
 */
module pkt_upsizer
    import pkt_width_pkg::*;
(
    input  logic         from_tx,
    input  logic         rst_n,
    input  logic         in_valid,
    input  narrow_word_t in_word,
    output logic         in_rdy,
    output logic         wide_push,
    output wide_word_t   wide_word,
    input  logic         credit_return
);

    logic [PACK_CNT_W-1:0]         pack_cnt;
    logic [PACK_CNT_W-1:0]         slot_idx;
    logic [CREDIT_W-1:0]           credits;
    logic                          grp_done;
    logic                          accept;
    narrow_data_t [0:CONV_RATIO-1] slots;
    logic                          sop_r;
    logic                          eop_r;
    logic                          err_r;
    logic [NARROW_MTY_W-1:0]       last_mty;
    logic [META_W-1:0]             meta_r;
    logic [WIDE_MTY_W-1:0]         wide_mty;

    assign wide_push = grp_done && (credits != '0);
    assign in_rdy    = !grp_done || wide_push;
    assign accept    = in_valid && in_rdy;

    // A word taken in the push cycle opens the next group at slot 0
    assign slot_idx = grp_done ? '0 : pack_cnt;

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            pack_cnt <= '0;
            grp_done <= 1'b0;
        end else if (accept) begin
            pack_cnt <= slot_idx + 1'b1;
            grp_done <= in_word.eop || (slot_idx == PACK_CNT_W'(CONV_RATIO - 1));
        end else if (wide_push) begin
            pack_cnt <= '0;
            grp_done <= 1'b0;
        end
    end

    // Group payload. The first word of a group clears the slots behind it
    always_ff @(posedge from_tx) begin
        if (accept) begin
            if (slot_idx == '0) begin
                slots <= '0;
                sop_r <= in_word.sop;
                err_r <= in_word.err;
            end else begin
                err_r <= err_r | in_word.err;
            end
            slots[slot_idx] <= in_word.data;
            eop_r           <= in_word.eop;
            last_mty        <= in_word.mty;
            if (in_word.sop) begin
                meta_r <= in_word.meta;
            end
        end
    end

    // Empty bytes are the unfilled slots plus the empty tail of the last word
    always_comb begin
        wide_mty = '0;
        if (eop_r) begin
            wide_mty = WIDE_MTY_W'(WIDE_BYTES - int'(pack_cnt) * NARROW_BYTES
                                   + int'(last_mty));
        end
    end

    assign wide_word.data = slots;
    assign wide_word.sop  = sop_r;
    assign wide_word.eop  = eop_r;
    assign wide_word.mty  = wide_mty;
    assign wide_word.err  = err_r;
    assign wide_word.meta = meta_r;

    // One credit per buffer entry, spent on push and returned on pop
    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(BUF_DEPTH);
        end else begin
            case ({wide_push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* verilog/pkt_credit_fifo.sv */
/*
 * Circular buffer of wide words between the upsizer and the downsizer.
 * The head entry is always presented and every pop sends one credit
 * back to the upsizer on the following cycle.
 */
module pkt_credit_fifo
    import pkt_width_pkg::*;
(
    input  logic       from_tx,
    input  logic       rst_n,
    input  logic       wide_push,
    input  wide_word_t wide_word,
    output logic       buf_valid,
    output wide_word_t buf_word,
    input  logic       buf_pop,
    output logic       credit_return
);

    wide_word_t          mem [BUF_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] fill_cnt;
    logic                do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign buf_valid = (fill_cnt != '0);
    assign buf_word  = mem[rd_ptr];

    // Pops of an empty buffer are ignored so no credit is invented
    assign do_pop = buf_pop && buf_valid;

    // The credit scheme keeps pushes from ever landing on a full buffer
    always_ff @(posedge from_tx) begin
        if (wide_push) begin
            mem[wr_ptr] <= wide_word;
        end
    end

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wide_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else begin
            case ({wide_push, do_pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop;
        end
    end

endmodule

/* verilog/pkt_downsizer.sv */
/*
 * Unpacks buffered wide words into narrow output words, slot 0 first.
 * The next wide word is popped in the cycle the last valid slot is
 * taken, so back-to-back wide words leave no bubble on the output.
 */
module pkt_downsizer
    import pkt_width_pkg::*;
(
    input  logic         from_tx,
    input  logic         rst_n,
    input  logic         buf_valid,
    input  wide_word_t   buf_word,
    output logic         buf_pop,
    output logic         out_valid,
    output narrow_word_t out_word,
    input  logic         out_rdy
);

    unpack_state_t                 state;
    logic [0:CONV_RATIO-1]         slot_vld;
    logic [0:CONV_RATIO-1]         load_vld;
    narrow_data_t [0:CONV_RATIO-1] slots;
    logic                          sop_r;
    logic                          eop_r;
    logic                          err_r;
    logic [WIDE_MTY_W-1:0]         mty_r;
    logic [META_W-1:0]             meta_r;
    logic                          take;
    logic                          last_slot;

    // A slot holds data when the empty tail does not reach its first byte
    always_comb begin
        for (int i = 0; i < CONV_RATIO; i++) begin
            load_vld[i] = (int'(buf_word.mty) < WIDE_BYTES - i * NARROW_BYTES);
        end
    end

    assign out_valid = (state == UNPACK_BUSY);
    assign take      = out_valid && out_rdy;
    assign last_slot = !slot_vld[1];
    assign buf_pop   = buf_valid && ((state == UNPACK_IDLE) || (take && last_slot));

    always_ff @(posedge from_tx or negedge rst_n) begin
        if (!rst_n) begin
            state    <= UNPACK_IDLE;
            slot_vld <= '0;
        end else if (buf_pop) begin
            state    <= UNPACK_BUSY;
            slot_vld <= load_vld;
        end else if (take) begin
            slot_vld <= slot_vld << 1;
            if (last_slot) begin
                state <= UNPACK_IDLE;
            end
        end
    end

    always_ff @(posedge from_tx) begin
        if (buf_pop) begin
            slots  <= buf_word.data;
            sop_r  <= buf_word.sop;
            eop_r  <= buf_word.eop;
            err_r  <= buf_word.err;
            mty_r  <= buf_word.mty;
            meta_r <= buf_word.meta;
        end else if (take) begin
            slots <= slots << (NARROW_BYTES * 8);
            // Only the first slot of the wide word may carry sop
            sop_r <= 1'b0;
        end
    end

    assign out_word.data = slots[0];
    assign out_word.sop  = sop_r;
    assign out_word.eop  = eop_r && last_slot;
    assign out_word.err  = err_r && eop_r && last_slot;
    assign out_word.meta = meta_r;

    always_comb begin
        out_word.mty = '0;
        if (eop_r && last_slot) begin
            out_word.mty = NARROW_MTY_W'(int'(mty_r) % NARROW_BYTES);
        end
    end

endmodule

/* verilog/pkt_width_bridge.sv */
/*
 * Top level of the packet width bridge.
 * Narrow words are packed by the upsizer, held in the credit buffer and
 * unpacked again by the downsizer. Both outer ports use valid/ready.
 */
module pkt_width_bridge
    import pkt_width_pkg::*;
(
    input  logic         from_tx,
    input  logic         rst_n,
    input  logic         in_valid,
    input  narrow_word_t in_word,
    output logic         in_rdy,
    output logic         out_valid,
    output narrow_word_t out_word,
    input  logic         out_rdy
);

    // Credit link between upsizer and buffer
    logic       wide_push;
    wide_word_t wide_word;
    logic       credit_return;

    // Head of buffer towards the downsizer
    logic       buf_valid;
    wide_word_t buf_word;
    logic       buf_pop;

    pkt_upsizer u_upsizer (
        .from_tx       (from_tx),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .in_rdy        (in_rdy),
        .wide_push     (wide_push),
        .wide_word     (wide_word),
        .credit_return (credit_return)
    );

    pkt_credit_fifo u_credit_fifo (
        .from_tx       (from_tx),
        .rst_n         (rst_n),
        .wide_push     (wide_push),
        .wide_word     (wide_word),
        .buf_valid     (buf_valid),
        .buf_word      (buf_word),
        .buf_pop       (buf_pop),
        .credit_return (credit_return)
    );

    pkt_downsizer u_downsizer (
        .from_tx   (from_tx),
        .rst_n     (rst_n),
        .buf_valid (buf_valid),
        .buf_word  (buf_word),
        .buf_pop   (buf_pop),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_rdy   (out_rdy)
    );

endmodule

/* dv/pkt_width_bridge_assertions.sv */
/*
 * Protocol checks for the packet width bridge, bound into the top level.
 * Watches the credit link, the buffer fill and the output handshake.
 */
module pkt_width_bridge_assertions
    import pkt_width_pkg::*;
(
    input logic                from_tx,
    input logic                rst_n,
    input logic                wide_push,
    input logic                credit_return,
    input logic [CREDIT_W-1:0] fill_cnt,
    input logic                out_valid,
    input logic                out_rdy,
    input narrow_word_t        out_word
);

    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench at the end of the run
    int fail_cnt = 0;

    // Credits left with the upsizer are the depth minus the filled entries
    // and any return still on its way back
    push_needs_credit: assert property (@(posedge from_tx) disable iff (!rst_n)
        wide_push |-> (int'(fill_cnt) + int'(credit_return) < BUF_DEPTH))
    else begin
        fail_cnt++;
        $error("wide_push issued while the upsizer held no credit");
    end

    fill_within_depth: assert property (@(posedge from_tx) disable iff (!rst_n)
        fill_cnt <= CREDIT_W'(BUF_DEPTH))
    else begin
        fail_cnt++;
        $error("credit buffer holds more entries than its depth");
    end

    // A stalled output word must not move or disappear
    out_held_when_stalled: assert property (@(posedge from_tx) disable iff (!rst_n)
        (out_valid && !out_rdy) |=> (out_valid && $stable(out_word)))
    else begin
        fail_cnt++;
        $error("out_word changed or out_valid dropped while out_rdy was low");
    end

endmodule

/* dv/pkt_width_bridge_tb.sv */
/*
 * Testbench for the packet width bridge. Input words, gaps, output stalls
 * and expected output words come from the testdata file. Output words are
 * checked in order while out_rdy is stalled from the file and at random.
 */
module pkt_width_bridge_tb
    import pkt_width_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int REC_FIELDS = 9;
    localparam int MEM_WORDS  = 512;
    localparam int RST_CYCLES = 16;
    localparam int DRAIN      = 20;
    localparam int SEED       = 32'h3d3475bd;

    logic         from_tx;
    logic         rst_n;
    logic         in_valid;
    narrow_word_t in_word;
    logic         in_rdy;
    logic         out_valid;
    narrow_word_t out_word;
    logic         out_rdy = 1'b0;

    logic [31:0]  raw [MEM_WORDS];
    narrow_word_t in_words [$];
    int           in_gaps [$];
    int           in_stalls [$];
    narrow_word_t exp_words [$];
    bit           rdy_pattern [$];

    int n_exp       = 0;
    int checked_cnt = 0;
    int mon_errors  = 0;
    int run_errors  = 0;
    int rdy_low_cnt = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;
    int stall_req   = 0;
    int stall_done  = 0;
    bit timed_out   = 1'b0;

    always #2 from_tx = ~from_tx;

    pkt_width_bridge DUT (
        .from_tx   (from_tx),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_rdy    (in_rdy),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_rdy   (out_rdy)
    );

    bind pkt_width_bridge pkt_width_bridge_assertions u_checks (
        .from_tx       (from_tx),
        .rst_n         (rst_n),
        .wide_push     (wide_push),
        .credit_return (credit_return),
        .fill_cnt      (u_credit_fifo.fill_cnt),
        .out_valid     (out_valid),
        .out_rdy       (out_rdy),
        .out_word      (out_word)
    );

    // Splits the flat record stream into input and expected queues
    task automatic load_testdata();
        int i;
        narrow_word_t w;
        for (i = 0; i < MEM_WORDS; i++) begin
            raw[i] = '0;
        end
        $readmemh("dv/pkt_width_testdata.txt", raw);
        i = 0;
        while (i + REC_FIELDS <= MEM_WORDS && raw[i] != '0) begin
            w.data = raw[i+1];
            w.sop  = raw[i+2][0];
            w.eop  = raw[i+3][0];
            w.mty  = raw[i+4][NARROW_MTY_W-1:0];
            w.err  = raw[i+5][0];
            w.meta = raw[i+6][META_W-1:0];
            if (raw[i] == 32'd1) begin
                in_words.push_back(w);
                in_gaps.push_back(int'(raw[i+7]));
                in_stalls.push_back(int'(raw[i+8]));
            end else if (raw[i] == 32'd2) begin
                exp_words.push_back(w);
            end else begin
                run_errors++;
                $display("Unknown record kind %0h in the testdata file", raw[i]);
                i = MEM_WORDS;
            end
            i += REC_FIELDS;
        end
    endtask

    task automatic send_word(input narrow_word_t w, input int gap, input int stall);
        int i;
        if (gap > 0) begin
            in_valid <= 1'b0;
            for (i = 0; i < gap; i++) begin
                @(posedge from_tx);
            end
        end
        in_valid  <= 1'b1;
        in_word   <= w;
        stall_req <= stall_req + stall;
        @(posedge from_tx);
        while (!in_rdy && !timed_out) begin
            @(posedge from_tx);
        end
    endtask

    task automatic check_field(input string name, input int idx,
                               input logic [31:0] got, input logic [31:0] expv);
        assert (got == expv) else begin
            mon_errors++;
            $display("ERROR %0t: output word %0d field %s is %0h, expected %0h",
                     $time, idx, name, got, expv);
        end
    endtask

    task automatic compare_word(input narrow_word_t got, input narrow_word_t expv,
                                input int idx);
        check_field("data", idx, got.data, expv.data);
        check_field("sop", idx, 32'(got.sop), 32'(expv.sop));
        check_field("eop", idx, 32'(got.eop), 32'(expv.eop));
        check_field("mty", idx, 32'(got.mty), 32'(expv.mty));
        check_field("err", idx, 32'(got.err), 32'(expv.err));
        check_field("meta", idx, 32'(got.meta), 32'(expv.meta));
    endtask

    task automatic check_reset_state(input string phase);
        assert (!out_valid && in_rdy) else begin
            run_errors++;
            $display("ERROR %0t: %s out_valid is %b and in_rdy is %b",
                     $time, phase, out_valid, in_rdy);
        end
    endtask

    // File stalls take priority over the random pattern
    always @(posedge from_tx) begin
        if (!rst_n) begin
            out_rdy <= 1'b0;
        end else if (stall_done < stall_req) begin
            out_rdy    <= 1'b0;
            stall_done <= stall_done + 1;
        end else begin
            out_rdy <= rdy_pattern[cycle_cnt % rdy_pattern.size()];
        end
    end

    always @(posedge from_tx) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            timed_out <= 1'b1;
        end
    end

    always @(posedge from_tx) begin
        if (rst_n && out_valid && out_rdy) begin
            if (checked_cnt < n_exp) begin
                compare_word(out_word, exp_words[checked_cnt], checked_cnt);
            end else begin
                mon_errors++;
                $display("An output word arrived after all expected words, at %0t", $time);
            end
            checked_cnt++;
        end
        if (rst_n && !in_rdy) begin
            rdy_low_cnt++;
        end
    end

    initial begin
        int i;
        int total_stall;
        int assert_fails;
        from_tx  = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        void'($urandom(SEED));
        load_testdata();
        n_exp = exp_words.size();
        total_stall = 0;
        foreach (in_stalls[k]) begin
            total_stall += in_stalls[k];
        end
        cycle_limit = 8 * in_words.size() + total_stall + 500;
        for (i = 0; i < cycle_limit; i++) begin
            rdy_pattern.push_back(($urandom % 4) != 0);
        end
        if (n_exp == 0) begin
            run_errors++;
            $display("No expected output words were loaded from the testdata file");
        end

        for (i = 0; i < RST_CYCLES; i++) begin
            @(posedge from_tx);
            if (i > 0) begin
                check_reset_state("during reset");
            end
        end
        rst_n <= 1'b1;
        @(posedge from_tx);
        check_reset_state("after reset");

        for (i = 0; i < in_words.size(); i++) begin
            if (!timed_out) begin
                send_word(in_words[i], in_gaps[i], in_stalls[i]);
            end
        end
        in_valid <= 1'b0;

        wait (checked_cnt >= n_exp || timed_out);
        if (!timed_out) begin
            repeat (DRAIN) @(posedge from_tx);
        end
        if (timed_out) begin
            $display("Timeout after %0d cycles, only %0d of %0d output words arrived",
                     cycle_limit, checked_cnt, n_exp);
        end
        // The long stall in the data must back up all the way to the input
        assert (rdy_low_cnt > 0) else begin
            run_errors++;
            $display("in_rdy never went low, so the buffer was never filled by a stall");
        end
        assert_fails = DUT.u_checks.fail_cnt;
        $display("Summary: %0d words checked, %0d mismatches, %0d other errors, %0d %s",
                 checked_cnt, mon_errors, run_errors, assert_fails, "assertion failures");
        if (mon_errors == 0 && run_errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/pkt_width_pkg.sv
verilog/pkt_upsizer.sv
verilog/pkt_credit_fifo.sv
verilog/pkt_downsizer.sv
verilog/pkt_width_bridge.sv
dv/pkt_width_bridge_assertions.sv
dv/pkt_width_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the packet width bridge testbench with Verilator, runs it and
# decides pass or fail from the simulation log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module pkt_width_bridge_tb \
    --Mdir "$BUILD_DIR" \
    -f flist.f

# Keep running after a failed bound assertion so the testbench can report it
"./$BUILD_DIR/Vpkt_width_bridge_tb" +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* dv/pkt_width_testdata.txt */
// Columns, all hex: kind data sop eop mty err meta gap stall
// Kind 1 is an input word (gap = idle cycles before it, stall = out_rdy low cycles
// started when it is driven), kind 2 is the next expected output word
// Single-word packets behind a long output stall
1 c0c1c2c3 1 1 0 0 a0 0 3c
1 c4c5c600 1 1 1 0 a1 0 0
1 c8c90000 1 1 2 1 a2 0 0
1 cc000000 1 1 3 0 a3 0 0
1 d0d1d2d3 1 1 0 1 a4 0 0
2 c0c1c2c3 1 1 0 0 a0 0 0
2 c4c5c600 1 1 1 0 a1 0 0
2 c8c90000 1 1 2 1 a2 0 0
2 cc000000 1 1 3 0 a3 0 0
2 d0d1d2d3 1 1 0 1 a4 0 0
// Packets of one to four bytes
1 a1b2c300 1 1 1 0 11 0 0
1 deadbeef 1 1 0 1 22 2 0
1 5a000000 1 1 3 0 33 0 0
2 a1b2c300 1 1 1 0 11 0 0
2 deadbeef 1 1 0 1 22 0 0
2 5a000000 1 1 3 0 33 0 0
// Seven bytes, err in the only group, other meta on the second word
1 01020304 1 0 0 1 44 1 0
1 05060700 0 1 1 0 99 0 0
2 01020304 1 0 0 0 44 0 0
2 05060700 0 1 1 1 44 0 0
// Twenty-two bytes over two groups, err only in the first group
1 10111213 1 0 0 0 55 0 14
1 14151617 0 0 0 1 55 0 0
1 18191a1b 0 0 0 0 77 0 0
1 1c1d1e1f 0 0 0 0 55 0 0
1 20212223 0 0 0 0 55 0 0
1 24250000 0 1 2 0 66 0 0
2 10111213 1 0 0 0 55 0 0
2 14151617 0 0 0 0 55 0 0
2 18191a1b 0 0 0 0 55 0 0
2 1c1d1e1f 0 0 0 0 55 0 0
2 20212223 0 0 0 0 55 0 0
2 24250000 0 1 2 0 55 0 0
